//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/10ps -j 0
TOP       = tb_periph_bus
FILELIST  = compile.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = all tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then echo "PASS"; else echo "FAIL"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- compile.f
hdl/periph_pkg.sv
hdl/io_regs.sv
hdl/byte_fifo.sv
hdl/kbd_port.sv
hdl/sys_timer.sv
hdl/periph_decode.sv
hdl/periph_bus.sv
testbench/periph_bus_properties.sv
testbench/tb_periph_bus.sv

//--- hdl/byte_fifo.sv
// ********************
// show-ahead FIFO
// circular buffer, head always visible on rd_data_o
// ********************

`timescale 1ns/10ps
`default_nettype none

module byte_fifo #(
    parameter int ADDR_LEN   = 5,
    parameter int DATA_WIDTH = 8
) (
    input  wire logic                  clk,
    input  wire logic                  reset_i,
    input  wire logic [DATA_WIDTH-1:0] wr_data_i,
    input  wire logic                  wr_en_i,
    output logic                       full_o,
    output logic [DATA_WIDTH-1:0]      rd_data_o,
    input  wire logic                  rd_en_i,
    output logic                       empty_o
);

    localparam int DEPTH = 2 ** ADDR_LEN;
    localparam int CNT_W = ADDR_LEN + 1;

    logic [DATA_WIDTH-1:0] mem [DEPTH];
    logic [ADDR_LEN-1:0]   wr_ptr;
    logic [ADDR_LEN-1:0]   rd_ptr;
    logic [CNT_W-1:0]      count;

    assign full_o    = (count == CNT_W'(DEPTH));
    assign empty_o   = (count == '0);
    assign rd_data_o = mem[rd_ptr];

    // writer keeps wr_en low while full, reader keeps rd_en low while empty
    always_ff @(posedge clk) begin
        if (wr_en_i)
            mem[wr_ptr] <= wr_data_i;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en_i)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_en_i)
                rd_ptr <= rd_ptr + 1'b1;
            if (wr_en_i && !rd_en_i)
                count <= count + 1'b1;
            else if (rd_en_i && !wr_en_i)
                count <= count - 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hdl/io_regs.sv
// ********************
// display byte and SD card SPI pins
// ********************

`timescale 1ns/10ps
`default_nettype none

module io_regs (
    input  wire logic              clk,
    input  wire logic              reset_i,
    input  wire logic              display_we_i,
    input  wire logic              sd_we_i,
    input  wire periph_pkg::word_t wdata_i,
    output periph_pkg::byte_t      display_o,
    output logic                   sd_csn_o,
    output logic                   sd_sclk_o,
    output logic                   sd_mosi_o
);

    import periph_pkg::*;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            display_o <= '0;
            // card deselected, clock idle low
            sd_sclk_o <= 1'b0;
            sd_csn_o  <= 1'b1;
            sd_mosi_o <= 1'b0;
        end else begin
            if (display_we_i)
                display_o <= byte_t'(wdata_i[7:0]);
            // bit 1 is written as asserted, pin is active low
            if (sd_we_i) begin
                sd_sclk_o <= wdata_i[2];
                sd_csn_o  <= ~wdata_i[1];
                sd_mosi_o <= wdata_i[0];
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/kbd_port.sv
// ********************
// keyboard port
// PS/2 code queue and the code register read by the cpu
// ********************

`timescale 1ns/10ps
`default_nettype none

module kbd_port #(
    parameter int KBD_DEPTH_LOG2 = 5
) (
    input  wire logic              clk,
    input  wire logic              reset_i,
    input  wire periph_pkg::byte_t code_i,
    input  wire logic              strobe_i,
    input  wire logic              deq_req_i,
    output logic                   ready_o,
    output periph_pkg::byte_t      code_o
);

    import periph_pkg::*;

    logic  fifo_full;
    logic  fifo_empty;
    logic  enq;
    logic  deq;
    byte_t head;

    // code lost when the queue is full
    assign enq     = strobe_i && !fifo_full;
    assign ready_o = !fifo_empty;

    byte_fifo #(
        .ADDR_LEN   (KBD_DEPTH_LOG2),
        .DATA_WIDTH ($bits(byte_t))
    ) u_fifo (
        .clk       (clk),
        .reset_i   (reset_i),
        .wr_data_i (code_i),
        .wr_en_i   (enq),
        .full_o    (fifo_full),
        .rd_data_o (head),
        .rd_en_i   (deq),
        .empty_o   (fifo_empty)
    );

    // pop one cycle after the request, head latched on the same edge
    always_ff @(posedge clk) begin
        if (reset_i) begin
            deq    <= 1'b0;
            code_o <= '0;
        end else begin
            deq <= deq_req_i && !fifo_empty;
            if (deq)
                code_o <= head;
        end
    end

endmodule

`default_nettype wire

//--- hdl/periph_bus.sv
// ********************
// peripheral region top
// bus decoder plus timer, keyboard queue, display and SD pins
// ********************

`timescale 1ns/10ps
`default_nettype none

module periph_bus #(
    parameter int FREQ_HZ        = 12_000_000,
    parameter int TICK_HZ        = 1000,
    parameter int KBD_DEPTH_LOG2 = 5
) (
    input  wire logic                clk,
    input  wire logic                reset_i,

    input  wire logic                sel_i,
    input  wire periph_pkg::word_t   addr_i,
    input  wire logic                we_i,
    input  wire periph_pkg::word_t   wdata_i,
    // every register sits in the low byte or is a full word
    input  wire logic [3:0]          wr_mask_i,
    output periph_pkg::word_t        rdata_o,
    output logic                     ack_o,

    output logic                     irq_o,
    input  wire logic                eoi_i,

    output periph_pkg::byte_t        display_o,

    input  wire periph_pkg::byte_t   kbd_code_i,
    input  wire logic                kbd_strobe_i,

    output logic                     sd_csn_o,
    output logic                     sd_sclk_o,
    output logic                     sd_mosi_o,
    input  wire logic                sd_miso_i
);

    import periph_pkg::*;

    // write strobes from the decoder
    logic timer_ena_we;
    logic display_we;
    logic sd_we;
    logic kbd_deq_req;

    // read sources
    logic  timer_ena;
    word_t clock_value;
    logic  kbd_ready;
    byte_t kbd_code;

    periph_decode u_decode (
        .clk            (clk),
        .reset_i        (reset_i),
        .sel_i          (sel_i),
        .addr_i         (addr_i),
        .we_i           (we_i),
        .ack_o          (ack_o),
        .rdata_o        (rdata_o),
        .timer_ena_we_o (timer_ena_we),
        .display_we_o   (display_we),
        .sd_we_o        (sd_we),
        .kbd_deq_req_o  (kbd_deq_req),
        .timer_ena_i    (timer_ena),
        .clock_value_i  (clock_value),
        .display_i      (display_o),
        .kbd_ready_i    (kbd_ready),
        .kbd_code_i     (kbd_code),
        .sd_miso_i      (sd_miso_i)
    );

    sys_timer #(
        .FREQ_HZ (FREQ_HZ),
        .TICK_HZ (TICK_HZ)
    ) u_timer (
        .clk           (clk),
        .reset_i       (reset_i),
        .ena_we_i      (timer_ena_we),
        .ena_data_i    (wdata_i[0]),
        .eoi_i         (eoi_i),
        .ena_o         (timer_ena),
        .clock_value_o (clock_value),
        .irq_o         (irq_o)
    );

    kbd_port #(
        .KBD_DEPTH_LOG2 (KBD_DEPTH_LOG2)
    ) u_kbd (
        .clk       (clk),
        .reset_i   (reset_i),
        .code_i    (kbd_code_i),
        .strobe_i  (kbd_strobe_i),
        .deq_req_i (kbd_deq_req),
        .ready_o   (kbd_ready),
        .code_o    (kbd_code)
    );

    io_regs u_io (
        .clk          (clk),
        .reset_i      (reset_i),
        .display_we_i (display_we),
        .sd_we_i      (sd_we),
        .wdata_i      (wdata_i),
        .display_o    (display_o),
        .sd_csn_o     (sd_csn_o),
        .sd_sclk_o    (sd_sclk_o),
        .sd_mosi_o    (sd_mosi_o)
    );

endmodule

`default_nettype wire

//--- hdl/periph_decode.sv
// ********************
// peripheral bus decoder
// acknowledge, write strobes and read multiplexer
// ********************

`timescale 1ns/10ps
`default_nettype none

module periph_decode (
    input  wire logic              clk,
    input  wire logic              reset_i,

    input  wire logic              sel_i,
    input  wire periph_pkg::word_t addr_i,
    input  wire logic              we_i,
    output logic                   ack_o,
    output periph_pkg::word_t      rdata_o,

    output logic                   timer_ena_we_o,
    output logic                   display_we_o,
    output logic                   sd_we_o,
    output logic                   kbd_deq_req_o,

    input  wire logic              timer_ena_i,
    input  wire periph_pkg::word_t clock_value_i,
    input  wire periph_pkg::byte_t display_i,
    input  wire logic              kbd_ready_i,
    input  wire periph_pkg::byte_t kbd_code_i,
    input  wire logic              sd_miso_i
);

    import periph_pkg::*;

    logic [3:0] region;
    dev_idx_t   dev;
    reg_off_t   off;
    logic       in_window;
    logic       wr_first;

    assign region    = addr_i[31:28];
    assign dev       = addr_i[15:12];
    assign off       = addr_i[11:0];
    assign in_window = (region == REGION_PERIPH);

    // ack stays high for as long as the master holds sel
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= sel_i && in_window;
        end
    end

    // first selected cycle only, so each write lands once
    assign wr_first = sel_i && we_i && in_window && !ack_o;

    always_comb begin
        timer_ena_we_o = 1'b0;
        display_we_o   = 1'b0;
        sd_we_o        = 1'b0;
        kbd_deq_req_o  = 1'b0;
        if (wr_first) begin
            case (dev)
                DEV_SYSTEM:  timer_ena_we_o = (off == REG_OFF_0);
                DEV_DISPLAY: display_we_o   = 1'b1;
                DEV_KBD:     kbd_deq_req_o  = (off == REG_OFF_0);
                DEV_SD:      sd_we_o        = (off == REG_OFF_0);
                default:     ;
            endcase
        end
    end

    // read map, holes read as zero
    always_comb begin
        rdata_o = '0;
        if (in_window) begin
            case (dev)
                DEV_SYSTEM: begin
                    if (off == REG_OFF_0)
                        rdata_o = word_t'(timer_ena_i);
                    else if (off == REG_OFF_4)
                        rdata_o = clock_value_i;
                end
                // display answers at any offset
                DEV_DISPLAY: rdata_o = word_t'(display_i);
                DEV_KBD: begin
                    if (off == REG_OFF_0)
                        rdata_o = word_t'(kbd_ready_i);
                    else if (off == REG_OFF_4)
                        rdata_o = word_t'(kbd_code_i);
                end
                DEV_SD: begin
                    if (off == REG_OFF_0)
                        rdata_o = word_t'(sd_miso_i);
                end
                default: rdata_o = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/periph_pkg.sv
// ********************
// peripheral region package
// word widths, device numbers and register offsets
// ********************

`default_nettype none

package periph_pkg;

    // bus data and address
    typedef logic [31:0] word_t;

    // display value or keyboard code
    typedef logic [7:0] byte_t;

    // device field, address bits 15..12
    typedef logic [3:0] dev_idx_t;

    // register offset inside a device, bits 11..0
    typedef logic [11:0] reg_off_t;

    // top address nibble of the peripheral window
    localparam logic [3:0] REGION_PERIPH = 4'h2;

    // device numbers
    localparam dev_idx_t DEV_SYSTEM  = 4'd0;
    localparam dev_idx_t DEV_DISPLAY = 4'd1;
    localparam dev_idx_t DEV_KBD     = 4'd5;
    localparam dev_idx_t DEV_SD      = 4'd6;

    // register offsets
    localparam reg_off_t REG_OFF_0 = 12'd0;
    localparam reg_off_t REG_OFF_4 = 12'd4;

endpackage

`default_nettype wire

//--- hdl/sys_timer.sv
// ********************
// system timer
// tick divider, ms counter and timer interrupt exchange
// ********************

`timescale 1ns/10ps
`default_nettype none

module sys_timer #(
    parameter int FREQ_HZ = 12_000_000,
    parameter int TICK_HZ = 1000
) (
    input  wire logic         clk,
    input  wire logic         reset_i,
    input  wire logic         ena_we_i,
    input  wire logic         ena_data_i,
    input  wire logic         eoi_i,
    output logic              ena_o,
    output periph_pkg::word_t clock_value_o,
    output logic              irq_o
);

    import periph_pkg::*;

    localparam int TICK_DIV = FREQ_HZ / TICK_HZ;

    word_t div_cnt;
    logic  tick;
    // set by a raised irq, cleared once the cpu drops eoi
    logic  wait_handling;

    assign tick = (div_cnt == '0);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            div_cnt       <= word_t'(TICK_DIV - 1);
            clock_value_o <= '0;
            ena_o         <= 1'b0;
            irq_o         <= 1'b0;
            wait_handling <= 1'b0;
        end else begin
            if (ena_we_i)
                ena_o <= ena_data_i;

            if (wait_handling) begin
                if (!eoi_i)
                    wait_handling <= 1'b0;
            end else if (irq_o && eoi_i) begin
                irq_o <= 1'b0;
            end

            div_cnt <= div_cnt - 1'b1;
            if (tick) begin
                div_cnt       <= word_t'(TICK_DIV - 1);
                clock_value_o <= clock_value_o + 1'b1;
                // a tick while still waiting is dropped
                if (ena_o && eoi_i && !wait_handling) begin
                    irq_o         <= 1'b1;
                    wait_handling <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- testbench/periph_bus_properties.sv
// ********************
// bus and reset assertions for the peripheral top
// ********************

`timescale 1ns/10ps
`default_nettype none

module periph_bus_properties (
    input wire logic clk,
    input wire logic reset_i,
    input wire logic sel_i,
    input wire logic ack_i,
    input wire logic sd_csn_i
);

    // ack only ever follows a select
    a_ack_after_sel: assert property (@(posedge clk) disable iff (reset_i)
        ack_i |-> $past(sel_i))
        else $error("ack without a select in the previous cycle");

    a_ack_low_after_reset: assert property (@(posedge clk) reset_i |=> !ack_i)
        else $error("ack high in the cycle after reset");

    // card deselected out of reset
    a_csn_high_after_reset: assert property (@(posedge clk) reset_i |=> sd_csn_i)
        else $error("sd chip select asserted in the cycle after reset");

endmodule

bind periph_bus periph_bus_properties u_periph_bus_properties (
    .clk      (clk),
    .reset_i  (reset_i),
    .sel_i    (sel_i),
    .ack_i    (ack_o),
    .sd_csn_i (sd_csn_o)
);

`default_nettype wire

//--- testbench/tb_periph_bus.sv
// ********************
// testbench for the peripheral region
// CPU bus model, device models and random tests
// ********************

`timescale 1ns/10ps
`default_nettype none

module tb_periph_bus;

    import periph_pkg::*;

    localparam int FREQ_HZ        = 1000;
    localparam int TICK_HZ        = 100;
    localparam int TICK_DIV       = FREQ_HZ / TICK_HZ;
    localparam int KBD_DEPTH      = 4;
    localparam int TIMEOUT_CYCLES = 20000;

    logic       clk;
    logic       reset_i;
    logic       sel_i;
    word_t      addr_i;
    logic       we_i;
    word_t      wdata_i;
    logic [3:0] wr_mask_i;
    word_t      rdata_o;
    logic       ack_o;
    logic       irq_o;
    logic       eoi_i;
    byte_t      display_o;
    byte_t      kbd_code_i;
    logic       kbd_strobe_i;
    logic       sd_csn_o;
    logic       sd_sclk_o;
    logic       sd_mosi_o;
    logic       sd_miso_i;

    // models
    byte_t display_model;
    byte_t kbd_model[$];
    byte_t last_code;
    word_t posedges_since_reset;
    word_t posedges_at_sample;
    int    cycle_count = 0;

    periph_bus #(
        .FREQ_HZ        (FREQ_HZ),
        .TICK_HZ        (TICK_HZ),
        .KBD_DEPTH_LOG2 (2)
    ) u_periph_bus (
        .clk          (clk),
        .reset_i      (reset_i),
        .sel_i        (sel_i),
        .addr_i       (addr_i),
        .we_i         (we_i),
        .wdata_i      (wdata_i),
        .wr_mask_i    (wr_mask_i),
        .rdata_o      (rdata_o),
        .ack_o        (ack_o),
        .irq_o        (irq_o),
        .eoi_i        (eoi_i),
        .display_o    (display_o),
        .kbd_code_i   (kbd_code_i),
        .kbd_strobe_i (kbd_strobe_i),
        .sd_csn_o     (sd_csn_o),
        .sd_sclk_o    (sd_sclk_o),
        .sd_mosi_o    (sd_mosi_o),
        .sd_miso_i    (sd_miso_i)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // reference for the ms counter, one tick per TICK_DIV edges
    always @(posedge clk) begin
        if (reset_i)
            posedges_since_reset <= '0;
        else
            posedges_since_reset <= posedges_since_reset + 1;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1, "run stopped on first error");
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
            abort_run("timeout: the tests did not finish within the cycle limit");
    end

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp)
            abort_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_byte(input string name, input byte_t exp, input byte_t act);
        if (act !== exp)
            abort_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
            abort_run($sformatf("mismatch %s expected %b actual %b", name, exp, act));
    endtask

    // address bits 27..16 are don't care, so they get random values
    function automatic word_t make_addr(input dev_idx_t dev, input reg_off_t off);
        logic [11:0] mid;
        mid = 12'($urandom);
        return {REGION_PERIPH, mid, dev, off};
    endfunction

    // called on a falling edge, returns one falling edge after sel drops
    task automatic bus_access(input word_t addr, input logic we, input word_t wdata,
                              output word_t rdata);
        sel_i     = 1'b1;
        addr_i    = addr;
        we_i      = we;
        wdata_i   = wdata;
        wr_mask_i = we ? 4'hf : 4'h0;
        @(negedge clk);
        while (!ack_o)
            @(negedge clk);
        rdata              = rdata_o;
        posedges_at_sample = posedges_since_reset;
        sel_i              = 1'b0;
        we_i               = 1'b0;
        @(negedge clk);
    endtask

    task automatic bus_write(input word_t addr, input word_t wdata);
        word_t unused;
        bus_access(addr, 1'b1, wdata, unused);
    endtask

    task automatic bus_read(input word_t addr, output word_t rdata);
        bus_access(addr, 1'b0, '0, rdata);
    endtask

    task automatic wait_irq(input logic level, input int max_cycles, input string name);
        int n;
        n = 0;
        while (irq_o !== level && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        check_bit(name, level, irq_o);
    endtask

    task automatic check_reset_values();
        check_bit("reset_ack", 1'b0, ack_o);
        check_bit("reset_irq", 1'b0, irq_o);
        check_byte("reset_display", 8'h00, display_o);
        check_bit("reset_sclk", 1'b0, sd_sclk_o);
        check_bit("reset_mosi", 1'b0, sd_mosi_o);
        check_bit("reset_csn", 1'b1, sd_csn_o);
    endtask

    task automatic test_clock_counter();
        word_t rd;
        repeat (40) begin
            repeat ($urandom_range(0, 15)) @(negedge clk);
            bus_read(make_addr(DEV_SYSTEM, REG_OFF_4), rd);
            check_word("clock_value", posedges_at_sample / word_t'(TICK_DIV), rd);
        end
    endtask

    task automatic test_display();
        word_t wd;
        word_t rd;
        repeat (30) begin
            wd = $urandom;
            bus_write(make_addr(DEV_DISPLAY, reg_off_t'($urandom)), wd);
            display_model = wd[7:0];
            check_byte("display_pin", display_model, display_o);
            bus_read(make_addr(DEV_DISPLAY, reg_off_t'($urandom)), rd);
            check_word("display_read", word_t'(display_model), rd);
        end
    endtask

    task automatic test_sd_port();
        word_t wd;
        word_t rd;
        logic  miso;
        repeat (20) begin
            wd = $urandom;
            bus_write(make_addr(DEV_SD, REG_OFF_0), wd);
            check_bit("sd_sclk", wd[2], sd_sclk_o);
            check_bit("sd_csn", ~wd[1], sd_csn_o);
            check_bit("sd_mosi", wd[0], sd_mosi_o);
            miso      = ($urandom_range(0, 1) == 1);
            sd_miso_i = miso;
            bus_read(make_addr(DEV_SD, REG_OFF_0), rd);
            check_word("sd_miso", word_t'(miso), rd);
        end
    endtask

    task automatic test_kbd_queue();
        word_t rd;
        byte_t code;
        repeat (12) begin
            // one strobe per cycle, the model drops codes while full
            repeat ($urandom_range(1, 6)) begin
                code         = byte_t'($urandom);
                kbd_code_i   = code;
                kbd_strobe_i = 1'b1;
                if (kbd_model.size() < KBD_DEPTH)
                    kbd_model.push_back(code);
                @(negedge clk);
            end
            kbd_strobe_i = 1'b0;
            bus_read(make_addr(DEV_KBD, REG_OFF_0), rd);
            check_word("kbd_status", word_t'(kbd_model.size() != 0), rd);
            repeat ($urandom_range(0, 4)) begin
                bus_write(make_addr(DEV_KBD, REG_OFF_0), $urandom);
                if (kbd_model.size() != 0)
                    last_code = kbd_model.pop_front();
                bus_read(make_addr(DEV_KBD, REG_OFF_4), rd);
                check_byte("kbd_code", last_code, rd[7:0]);
                check_word("kbd_code_upper", 32'h0, {rd[31:8], 8'h00});
                bus_read(make_addr(DEV_KBD, REG_OFF_0), rd);
                check_word("kbd_status", word_t'(kbd_model.size() != 0), rd);
            end
        end
    endtask

    task automatic test_timer_irq();
        word_t rd;
        logic  ena;
        // eoi low keeps the exchange idle while the enable toggles
        eoi_i = 1'b0;
        repeat (20) begin
            ena = ($urandom_range(0, 1) == 1);
            bus_write(make_addr(DEV_SYSTEM, REG_OFF_0), word_t'(ena));
            bus_read(make_addr(DEV_SYSTEM, REG_OFF_0), rd);
            check_word("timer_enable", word_t'(ena), rd);
            check_bit("irq_eoi_low", 1'b0, irq_o);
        end
        repeat (3) begin
            bus_write(make_addr(DEV_SYSTEM, REG_OFF_0), 32'h1);
            eoi_i = 1'b1;
            wait_irq(1'b1, TICK_DIV, "irq_rise");
            // end-of-interrupt pulse low for one cycle
            eoi_i = 1'b0;
            @(negedge clk);
            eoi_i = 1'b1;
            wait_irq(1'b0, 2, "irq_fall");
            bus_write(make_addr(DEV_SYSTEM, REG_OFF_0), 32'h0);
            repeat (30) begin
                @(negedge clk);
                check_bit("irq_disabled", 1'b0, irq_o);
            end
        end
    endtask

    task automatic test_outside_window();
        word_t      rd;
        logic [3:0] nib;
        repeat (10) begin
            nib = 4'($urandom_range(0, 14));
            if (nib >= REGION_PERIPH)
                nib = nib + 4'h1;
            // aimed at the display field, so a stray write would show
            sel_i     = 1'b1;
            addr_i    = {nib, 12'($urandom), DEV_DISPLAY, reg_off_t'($urandom)};
            we_i      = 1'b1;
            wdata_i   = $urandom;
            wr_mask_i = 4'hf;
            repeat (4) begin
                @(negedge clk);
                check_bit("outside_no_ack", 1'b0, ack_o);
            end
            sel_i = 1'b0;
            we_i  = 1'b0;
            @(negedge clk);
            check_byte("outside_display_pin", display_model, display_o);
            bus_read(make_addr(DEV_DISPLAY, REG_OFF_0), rd);
            check_word("outside_display_read", word_t'(display_model), rd);
        end
    endtask

    initial begin
        void'($urandom(7873));
        reset_i       = 1'b1;
        sel_i         = 1'b0;
        addr_i        = '0;
        we_i          = 1'b0;
        wdata_i       = '0;
        wr_mask_i     = 4'h0;
        eoi_i         = 1'b0;
        kbd_code_i    = '0;
        kbd_strobe_i  = 1'b0;
        sd_miso_i     = 1'b0;
        display_model = '0;
        last_code     = '0;
        // three rising edges in reset, release on the next falling edge
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        check_reset_values();
        test_clock_counter();
        test_display();
        test_sd_port();
        test_kbd_queue();
        test_timer_irq();
        test_outside_window();
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire
